// File: dmm_spi_ctl.f
src/dmm_spi_ctl_pkg.sv
src/spi_shifter.sv
src/register_set.sv
src/spi_mux.sv
src/led_mode_mux.sv
src/dmm_spi_ctl_top.sv
sim/dmm_spi_ctl_assert.sv
sim/tb_dmm_spi_ctl.sv

// File: sim/tb_dmm_spi_ctl.sv
/*
  dmm spi control testbench
  bit-bangs spi frames into the top level, keeps a register model,
  and checks readback, leds, lane passthrough and the write count
*/
`timescale 1ns/1ps

module tb_dmm_spi_ctl;
  import dmm_spi_ctl_pkg::*;

  localparam int HALF_SCK = 6;      // clk cycles per sck phase
  localparam int HB_LIMIT = 4500;   // heartbeat toggle bound

  logic                  clk;
  logic                  reset;
  logic                  sck;
  logic                  sdi;
  logic                  ss;
  logic                  cs2;
  logic [3:0]            hw_flags;
  logic [LANE_COUNT-1:0] lane_miso;
  logic                  sdo;
  lane_bus_t             lanes;
  logic                  oe_4094;
  led_t                  leds;

  integer     seed = 32'h6fe;
  int         errors;
  int         checks;
  int         tests;
  int         test_start_errs;
  int         accepted_total;   // never wraps, unlike the dut count
  word_t      model_regs [0:3];  // writable regs as read back
  logic [7:0] model_count;

  dmm_spi_ctl_top DUT (
    .clk       (clk),
    .reset     (reset),
    .sck       (sck),
    .sdi       (sdi),
    .ss        (ss),
    .cs2       (cs2),
    .hw_flags  (hw_flags),
    .lane_miso (lane_miso),
    .sdo       (sdo),
    .lanes     (lanes),
    .oe_4094   (oe_4094),
    .leds      (leds)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;   // 10 ns

  //////////////////////////////////////////////////
  // model

  function automatic word_t reg_mask(input logic [3:0] addr);
    case (addr)
      4'd0:    return 32'h0000_00ff;   // lane select
      4'd1:    return 32'h0000_0001;   // oe only
      4'd2:    return 32'h007f_ffff;   // mode + 20 spare bits
      4'd3:    return 32'hffff_ffff;
      default: return 32'h0;
    endcase
  endfunction

  function automatic word_t model_read(input logic [3:0] addr);
    if (addr < 4'd4) return model_regs[addr[1:0]];
    if (addr == 4'd4) return {16'h0, model_count, 4'h0, hw_flags};   // status
    return 32'h0;
  endfunction

  task automatic model_apply(input logic [3:0] op, input logic [3:0] addr, input word_t data);
    word_t old;
    word_t nxt;
    if (addr < 4'd4 && op >= 4'd1 && op <= 4'd4) begin
      old = model_regs[addr[1:0]];
      case (op)
        4'd1:    nxt = data;
        4'd2:    nxt = old | data;
        4'd3:    nxt = old & ~data;
        default: nxt = old ^ data;   // toggle
      endcase
      model_regs[addr[1:0]] = nxt & reg_mask(addr);
      model_count = model_count + 8'd1;
      accepted_total++;
    end
  endtask

  function automatic led_t expected_leds(input int mode, input word_t d);
    case (mode)
      0:       return d[3:0];
      1:       return {d[0], d[1], d[2], d[3]};
      2:       return 4'hf;
      default: return 4'h0;   // off and 5..7
    endcase
  endfunction

  function automatic lane_bus_t lane_expect(input logic [7:0] sel, input logic cs2_pin,
                                            input logic sck_pin, input logic sdi_pin);
    lane_bus_t l;
    for (int i = 0; i < LANE_COUNT; i++) begin
      l.lane_cs[i] = (sel[i] && !cs2_pin) ? CS_POLARITY[i] : !CS_POLARITY[i];
    end
    l.lane_clk  = sel & {LANE_COUNT{sck_pin}};
    l.lane_mosi = sel & {LANE_COUNT{sdi_pin}};
    return l;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_leds(input string name, input led_t got, input led_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_lanes(input string name, input lane_bus_t got, input lane_bus_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %06h expected %06h", $time, name, got, exp);
    end
  endtask

  task automatic start_test();
    test_start_errs = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_start_errs) $display("test %-14s ok", name);
    else $display("test %-14s %0d errors", name, errors - test_start_errs);
  endtask

  //////////////////////////////////////////////////
  // spi master

  // mode 0 msb first, sdo sampled just before each rising sck
  task automatic spi_frame(input int nbits, input spi_frame_t tx, output word_t rx);
    logic [FRAME_BITS-1:0] bits;
    bits = tx;
    rx   = '0;
    @(posedge clk);
    ss  <= 1'b0;
    sck <= 1'b0;
    repeat (HALF_SCK) @(posedge clk);
    for (int i = 0; i < nbits; i++) begin
      sdi <= bits[FRAME_BITS-1-i];   // changes with falling sck
      repeat (HALF_SCK - 1) @(posedge clk);
      @(negedge clk);
      if (i >= CMD_BITS) rx = {rx[30:0], sdo};
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF_SCK) @(posedge clk);
      sck <= 1'b0;
    end
    repeat (HALF_SCK) @(posedge clk);
    ss  <= 1'b1;
    sdi <= 1'b0;
    repeat (4 * HALF_SCK) @(posedge clk);   // sync + update + led reg
  endtask

  // full frame with readback and model update
  task automatic run_frame(input logic [3:0] op, input logic [3:0] addr, input word_t data);
    spi_frame_t fr;
    word_t      exp_rd;
    word_t      rx;
    fr.cmd.op   = spi_op_e'(op);
    fr.cmd.addr = reg_addr_e'(addr);
    fr.data     = data;
    exp_rd      = model_read(addr);   // value before the frame
    spi_frame(FRAME_BITS, fr, rx);
    check_word("sdo_readback", rx, exp_rd);
    model_apply(op, addr, data);
    check_word("oe_4094", {31'h0, oe_4094}, model_regs[1]);
  endtask

  task automatic read_all();
    for (int a = 0; a < 16; a++) begin
      run_frame(op_read, 4'(a), $random(seed));
    end
  endtask

  task automatic check_heartbeat();
    led_t first;
    logic toggled;
    logic bad;
    int   cyc;
    first   = leds;
    toggled = 1'b0;
    bad     = 1'b0;
    cyc     = 0;
    while (!toggled && !bad && cyc < HB_LIMIT) begin
      @(negedge clk);
      cyc++;
      if (leds !== 4'h0 && leds !== 4'hf) bad = 1'b1;   // leds must move together
      else if (leds !== first) toggled = 1'b1;
    end
    checks++;
    if (bad) begin
      errors++;
      $display("error at %0t: leds got %b expected 0000 or 1111", $time, leds);
    end else if (!toggled) begin
      errors++;
      $display("heartbeat leds did not toggle within %0d clk cycles", HB_LIMIT);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] r;
    logic [3:0]  op;
    logic [3:0]  addr;
    logic [7:0]  sel;
    spi_frame_t  fr;
    word_t       rx;
    int          nbits;
    int          assert_fails;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    accepted_total = 0;
    model_count    = 8'h0;
    for (int a = 0; a < 4; a++) model_regs[a] = 32'h0;
    reset     = 1'b1;
    sck       = 1'b0;
    sdi       = 1'b0;
    ss        = 1'b1;
    cs2       = 1'b1;
    lane_miso = '0;
    hw_flags  = 4'($random(seed));   // fixed for the run
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // 1 reset state
    start_test();
    @(negedge clk);
    check_leds("leds", leds, 4'h0);
    check_word("oe_4094", {31'h0, oe_4094}, 32'h0);
    check_lanes("lanes", lanes, lane_expect(8'h00, 1'b1, 1'b0, 1'b0));
    read_all();
    finish_test("reset_values");

    // 2 random frames, biased toward defined ops and addresses
    start_test();
    for (int n = 0; n < 200; n++) begin
      r    = $random(seed);
      op   = (r[9:8] == 2'b00) ? r[3:0] : 4'(r[6:4] % 5);
      addr = (r[11:10] == 2'b00) ? r[15:12] : 4'(r[14:12] % 5);
      run_frame(op, addr, $random(seed));
    end
    read_all();
    finish_test("random_frames");

    // 3 led modes
    start_test();
    for (int m = 0; m < 8; m++) begin
      r = $random(seed);
      run_frame(op_write, addr_direct, $random(seed));
      run_frame(op_write, addr_mode, {r[31:3], 3'(m)});   // spare bits random
      @(negedge clk);
      if (m == 4) check_heartbeat();
      else check_leds("leds", leds, expected_leds(m, model_regs[3]));
    end
    finish_test("led_modes");

    // 4 cs2 passthrough
    start_test();
    sel = 8'($random(seed));
    run_frame(op_write, addr_spi_mux, {24'h0, sel});
    for (int n = 0; n < 32; n++) begin
      @(posedge clk);
      r = $random(seed);
      cs2       <= (n < 2 || n > 29);   // edges of the window deselected
      sck       <= r[0];
      sdi       <= r[1];
      lane_miso <= r[15:8];
      @(negedge clk);
      check_lanes("lanes", lanes, lane_expect(sel, cs2, sck, sdi));
      check_word("sdo", {31'h0, sdo}, {31'h0, !cs2 && |(lane_miso & sel)});
    end
    @(posedge clk);
    cs2       <= 1'b1;
    sck       <= 1'b0;
    sdi       <= 1'b0;
    lane_miso <= '0;
    @(negedge clk);
    check_lanes("lanes", lanes, lane_expect(sel, 1'b1, 1'b0, 1'b0));
    finish_test("cs2_passthru");

    // 5 frames cut off before bit 40
    start_test();
    for (int n = 0; n < 8; n++) begin
      r           = $random(seed);
      fr.cmd.op   = spi_op_e'(4'(1 + r[1:0]));   // write..toggle
      fr.cmd.addr = reg_addr_e'(4'(r[3:2]));     // writable only
      fr.data     = $random(seed);
      nbits       = 1 + (r[15:8] % 39);
      spi_frame(nbits, fr, rx);
    end
    read_all();
    finish_test("short_frames");

    // 6 write count, pushed past the 8 bit wrap
    start_test();
    for (int n = 0; n < 800 && accepted_total < 300; n++) begin
      r    = $random(seed);
      op   = r[3] ? 4'(1 + r[1:0]) : r[7:4];
      addr = r[8] ? 4'(r[10:9]) : r[15:12];
      run_frame(op, addr, $random(seed));
    end
    fr.cmd.op   = op_read;
    fr.cmd.addr = addr_status;
    fr.data     = 32'h0;
    spi_frame(FRAME_BITS, fr, rx);
    check_word("status", rx, model_read(4'd4));
    check_word("status_count", {24'h0, rx[15:8]}, 32'(accepted_total % 256));
    check_word("status_upper", rx & 32'hffff_00f0, 32'h0);
    finish_test("write_count");

    assert_fails = DUT.u_register_set.u_assert.fail_count;
    errors       = errors + assert_fails;
    $display("tests %0d  checks %0d  assertion failures %0d  errors %0d",
             tests, checks, assert_fails, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim/dmm_spi_ctl_assert.sv
/*
  dmm spi control assertions
  bound into the register set to check strobe width, register stability
  between frames and the reset state of the control registers
*/
`timescale 1ns/1ps

module dmm_spi_ctl_assert (
  input logic                       clk,
  input logic                       reset,
  input logic                       frame_valid,
  input dmm_spi_ctl_pkg::ctl_regs_t ctl_regs
);

  int fail_count = 0;   // failed assertions so far

  // frame strobe is a single clk pulse
  a_frame_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    frame_valid |=> !frame_valid)
  else begin
    fail_count++;
    $error("frame_valid high for two cycles in a row");
  end

  // regs only move on the clk after a completed frame
  a_regs_stable: assert property (@(posedge clk) disable iff (reset)
    !frame_valid |=> $stable(ctl_regs))
  else begin
    fail_count++;
    $error("ctl_regs changed without frame_valid");
  end

  a_regs_reset: assert property (@(posedge clk) reset |=> ctl_regs == '0)
  else begin
    fail_count++;
    $error("ctl_regs not zero after reset");
  end

endmodule

bind register_set dmm_spi_ctl_assert u_assert (
  .clk         (clk),
  .reset       (reset),
  .frame_valid (frame_valid),
  .ctl_regs    (ctl_regs)
);

// File: src/dmm_spi_ctl_top.sv
/*
  dmm spi control top
  host spi register access on ss, lane passthrough on cs2,
  relay chain output enable and the status leds
*/
`timescale 1ns/1ps

module dmm_spi_ctl_top (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   sck,
  input  logic                                   sdi,
  input  logic                                   ss,        // register select, active low
  input  logic                                   cs2,       // lane passthrough, active low
  input  logic [3:0]                             hw_flags,
  input  logic [dmm_spi_ctl_pkg::LANE_COUNT-1:0] lane_miso,
  output logic                                   sdo,
  output dmm_spi_ctl_pkg::lane_bus_t             lanes,
  output logic                                   oe_4094,
  output dmm_spi_ctl_pkg::led_t                  leds
);
  import dmm_spi_ctl_pkg::*;

  word_t      rd_data;
  logic       dout;       // shifter miso, muxed out
  logic       cmd_valid;
  spi_cmd_t   cmd;
  logic       frame_valid;
  spi_frame_t frame;
  ctl_regs_t  ctl_regs;

  //////////////////////////////////////////////////
  // register access path

  spi_shifter u_spi_shifter (
    .clk         (clk),
    .reset       (reset),
    .sck         (sck),
    .sdi         (sdi),
    .ss          (ss),
    .rd_data     (rd_data),
    .dout        (dout),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  register_set u_register_set (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .frame_valid (frame_valid),
    .cmd         (cmd),
    .frame       (frame),
    .hw_flags    (hw_flags),
    .rd_data     (rd_data),
    .ctl_regs    (ctl_regs)
  );

  //////////////////////////////////////////////////
  // outputs

  spi_mux u_spi_mux (
    .ctl_regs  (ctl_regs),
    .sck       (sck),
    .sdi       (sdi),
    .cs2       (cs2),
    .ss        (ss),
    .dout      (dout),
    .lane_miso (lane_miso),
    .lanes     (lanes),
    .sdo       (sdo)
  );

  led_mode_mux u_led_mode_mux (
    .clk      (clk),
    .reset    (reset),
    .ctl_regs (ctl_regs),
    .leds     (leds)
  );

  assign oe_4094 = ctl_regs.oe_4094;   // low out of reset, relays held off

endmodule

// File: src/led_mode_mux.sv
/*
  led pattern mux
  free running heartbeat plus a registered led pattern picked by the mode reg
*/
`timescale 1ns/1ps

module led_mode_mux (
  input  logic                       clk,
  input  logic                       reset,
  input  dmm_spi_ctl_pkg::ctl_regs_t ctl_regs,
  output dmm_spi_ctl_pkg::led_t      leds
);
  import dmm_spi_ctl_pkg::*;

  logic [HEARTBEAT_BITS-1:0] hb_cnt;
  logic                      heartbeat;
  led_t                      pattern;

  assign heartbeat = hb_cnt[HEARTBEAT_BITS-1];   // toggles every 2048 clk

  always_comb begin
    case (ctl_regs.mode)
      mode_direct:    pattern = ctl_regs.direct[3:0];
      mode_reversed:  pattern = {ctl_regs.direct[0], ctl_regs.direct[1],
                                 ctl_regs.direct[2], ctl_regs.direct[3]};   // bit order flipped
      mode_all_on:    pattern = 4'b1111;
      mode_off:       pattern = 4'b0000;
      mode_heartbeat: pattern = {4{heartbeat}};
      default:        pattern = 4'b0000;   // 5..7
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hb_cnt <= '0;
      leds   <= '0;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
      leds   <= pattern;   // one clk behind ctl_regs
    end
  end

endmodule

// File: src/spi_mux.sv
/*
  spi lane mux
  while cs2 is low the spi pins go to the lanes picked by spi_mux,
  each select at its own polarity; also picks the miso source
*/
`timescale 1ns/1ps

module spi_mux (
  input  dmm_spi_ctl_pkg::ctl_regs_t                 ctl_regs,
  input  logic                                       sck,
  input  logic                                       sdi,
  input  logic                                       cs2,
  input  logic                                       ss,
  input  logic                                       dout,
  input  logic [dmm_spi_ctl_pkg::LANE_COUNT-1:0]     lane_miso,
  output dmm_spi_ctl_pkg::lane_bus_t                 lanes,
  output logic                                       sdo
);
  import dmm_spi_ctl_pkg::*;

  logic                  cs2_active;   // cs2 is active low
  logic [LANE_COUNT-1:0] sel;
  logic                  lane_miso_any;

  assign cs2_active = ~cs2;
  assign sel        = ctl_regs.spi_mux;

  //////////////////////////////////////////////////
  // lane outputs

  always_comb begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      // active level from CS_POLARITY, 4094 strobe goes high
      if (sel[i] && cs2_active) begin
        lanes.lane_cs[i] = CS_POLARITY[i];
      end else begin
        lanes.lane_cs[i] = ~CS_POLARITY[i];
      end
      lanes.lane_clk[i]  = sel[i] & sck;   // idle lanes held low
      lanes.lane_mosi[i] = sel[i] & sdi;
    end
  end

  //////////////////////////////////////////////////
  // miso select

  assign lane_miso_any = |(lane_miso & sel);   // only selected lanes

  always_comb begin
    if (cs2_active) begin
      sdo = lane_miso_any;
    end else if (!ss) begin
      sdo = dout;          // register readback
    end else begin
      sdo = 1'b0;
    end
  end

endmodule

// File: src/register_set.sv
/*
  control register set
  tracks each frame with a small fsm, returns the pre-frame value for
  readback and applies write/set/clear/toggle when the frame completes
*/
`timescale 1ns/1ps

module register_set (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cmd_valid,
  input  logic                        frame_valid,
  input  dmm_spi_ctl_pkg::spi_cmd_t   cmd,
  input  dmm_spi_ctl_pkg::spi_frame_t frame,
  input  logic [3:0]                  hw_flags,
  output dmm_spi_ctl_pkg::word_t      rd_data,
  output dmm_spi_ctl_pkg::ctl_regs_t  ctl_regs
);
  import dmm_spi_ctl_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,    // readback just latched
    st_data    // waiting for the 40th bit
  } state_e;

  state_e     state;
  logic [7:0] wr_count;   // accepted writes, wraps
  word_t      status;
  word_t      cur_word;   // addressed reg before the frame
  word_t      new_word;
  logic       accepted;

  // register word as seen on the bus
  function automatic word_t read_word(input reg_addr_e addr, input ctl_regs_t regs,
                                      input word_t stat);
    word_t w;
    case (addr)
      addr_spi_mux: w = {24'h000000, regs.spi_mux};
      addr_4094:    w = {31'h00000000, regs.oe_4094};
      addr_mode:    w = {9'h000, regs.spare, regs.mode};   // bits 31..23 read zero
      addr_direct:  w = regs.direct;
      addr_status:  w = stat;
      default:      w = '0;                                 // unknown address
    endcase
    return w;
  endfunction

  function automatic word_t apply_op(input spi_op_e op, input word_t old, input word_t data);
    word_t w;
    case (op)
      op_write:  w = data;
      op_set:    w = old | data;
      op_clear:  w = old & ~data;
      op_toggle: w = old ^ data;
      default:   w = old;   // read and unused codes
    endcase
    return w;
  endfunction

  assign status = {16'h0000, wr_count, 4'h0, hw_flags};

  always_comb begin
    cur_word = read_word(frame.cmd.addr, ctl_regs, status);
    new_word = apply_op(frame.cmd.op, cur_word, frame.data);
    accepted = (frame.cmd.addr <= addr_direct) &&
               (frame.cmd.op inside {op_write, op_set, op_clear, op_toggle});
  end

  //////////////////////////////////////////////////
  // frame fsm

  // a cut off frame leaves the fsm in st_data, the next cmd restarts it
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (cmd_valid) state <= st_cmd;
        st_cmd:  state <= st_data;
        st_data: begin
          if (frame_valid) state <= st_idle;
          else if (cmd_valid) state <= st_cmd;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // readback captured as the fsm enters st_cmd, shifted out during data bits
  always_ff @(posedge clk) begin
    if (cmd_valid) rd_data <= read_word(cmd.addr, ctl_regs, status);
  end

  //////////////////////////////////////////////////
  // register update

  always_ff @(posedge clk) begin
    if (reset) begin
      ctl_regs <= '0;
      wr_count <= '0;
    end else if (frame_valid && state == st_data && accepted) begin
      wr_count <= wr_count + 8'd1;
      case (frame.cmd.addr)
        addr_spi_mux: ctl_regs.spi_mux <= new_word[7:0];
        addr_4094:    ctl_regs.oe_4094 <= new_word[0];
        addr_mode: begin
          ctl_regs.mode  <= led_mode_e'(new_word[2:0]);
          ctl_regs.spare <= new_word[22:3];
        end
        addr_direct:  ctl_regs.direct <= new_word;
        default:      ;   // not writable
      endcase
    end
  end

endmodule

// File: src/spi_shifter.sv
/*
  spi slave shifter
  syncs sck/sdi/ss into clk, deserializes 40 bit frames (mode 0, msb first)
  and shifts the readback word out on falling sck
*/
`timescale 1ns/1ps

module spi_shifter (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sck,
  input  logic                        sdi,
  input  logic                        ss,
  input  dmm_spi_ctl_pkg::word_t      rd_data,
  output logic                        dout,
  output logic                        cmd_valid,
  output dmm_spi_ctl_pkg::spi_cmd_t   cmd,
  output logic                        frame_valid,
  output dmm_spi_ctl_pkg::spi_frame_t frame
);
  import dmm_spi_ctl_pkg::*;

  logic [1:0]            sck_sync;   // two flop syncs
  logic [1:0]            sdi_sync;
  logic [1:0]            ss_sync;
  logic                  sck_prev;
  logic                  sdi_q;      // aligned with the edge pulses
  logic                  ss_q;
  logic                  sck_rise;
  logic                  sck_fall;
  logic [CNT_BITS-1:0]   bit_cnt;
  logic [FRAME_BITS-2:0] shift_in;   // newest bit at lsb
  logic                  load_pending;
  word_t                 shift_out;

  //////////////////////////////////////////////////
  // pin sync and edge detect

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync <= 2'b00;
      sdi_sync <= 2'b00;
      ss_sync  <= 2'b11;   // deselected
      sck_prev <= 1'b0;
      sdi_q    <= 1'b0;
      ss_q     <= 1'b1;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[0], sck};
      sdi_sync <= {sdi_sync[0], sdi};
      ss_sync  <= {ss_sync[0], ss};
      sck_prev <= sck_sync[1];
      sdi_q    <= sdi_sync[1];
      ss_q     <= ss_sync[1];
      sck_rise <= sck_sync[1] & ~sck_prev;   // one clk pulse
      sck_fall <= ~sck_sync[1] & sck_prev;
    end
  end

  //////////////////////////////////////////////////
  // input side

  // counts captured bits and holds at 40 so extra bits fall away
  always_ff @(posedge clk) begin
    if (reset || ss_q) begin
      bit_cnt <= '0;
    end else if (sck_rise && bit_cnt != CNT_BITS'(FRAME_BITS)) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid   <= 1'b0;
      frame_valid <= 1'b0;
    end else begin
      cmd_valid   <= sck_rise && !ss_q && bit_cnt == CNT_BITS'(CMD_BITS - 1);    // 8th bit
      frame_valid <= sck_rise && !ss_q && bit_cnt == CNT_BITS'(FRAME_BITS - 1);  // 40th bit
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (sck_rise && bit_cnt < CNT_BITS'(FRAME_BITS)) begin
      shift_in <= {shift_in[FRAME_BITS-3:0], sdi_q};
    end
    if (sck_rise && bit_cnt == CNT_BITS'(CMD_BITS - 1)) begin
      cmd <= spi_cmd_t'({shift_in[CMD_BITS-2:0], sdi_q});
    end
    if (sck_rise && bit_cnt == CNT_BITS'(FRAME_BITS - 1)) begin
      frame <= spi_frame_t'({shift_in, sdi_q});
    end
  end

  //////////////////////////////////////////////////
  // output side

  // rd_data arrives the clk after cmd_valid and is loaded one clk later.
  // first data bit is already on dout at that point, so the falling edge
  // right after bit 8 must not shift
  always_ff @(posedge clk) begin
    if (reset || ss_q) begin
      load_pending <= 1'b0;
      shift_out    <= '0;   // dout low between frames
    end else begin
      load_pending <= cmd_valid;
      if (load_pending) begin
        shift_out <= rd_data;
      end else if (sck_fall && bit_cnt > CNT_BITS'(CMD_BITS)) begin
        shift_out <= {shift_out[$bits(word_t)-2:0], 1'b0};   // msb first
      end
    end
  end

  assign dout = shift_out[$bits(word_t)-1];

endmodule

// File: src/dmm_spi_ctl_pkg.sv
/*
  dmm spi control package
  shared widths, opcodes, register addresses and the structs that carry
  frames, control registers and lane signals between blocks
*/
package dmm_spi_ctl_pkg;

  //////////////////////////////////////////////////
  // sizes

  localparam int LANE_COUNT     = 8;    // peripheral spi lanes
  localparam int FRAME_BITS     = 40;   // cmd byte + data word
  localparam int CMD_BITS       = 8;
  localparam int CNT_BITS       = $clog2(FRAME_BITS + 1);  // bit counter, saturates at 40
  localparam int HEARTBEAT_BITS = 12;   // msb toggles every 2048 clk

  // 1 = lane select active high, lane 0 is the 4094 strobe
  localparam logic [LANE_COUNT-1:0] CS_POLARITY = 8'b00000001;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  led_t;

  //////////////////////////////////////////////////
  // command byte fields

  typedef enum logic [3:0] {
    op_read   = 4'd0,
    op_write  = 4'd1,
    op_set    = 4'd2,   // or into reg
    op_clear  = 4'd3,   // clear bits set in data
    op_toggle = 4'd4    // xor into reg
  } spi_op_e;           // unlisted codes behave as read

  typedef enum logic [3:0] {
    addr_spi_mux = 4'd0,
    addr_4094    = 4'd1,
    addr_mode    = 4'd2,
    addr_direct  = 4'd3,
    addr_status  = 4'd4  // read only
  } reg_addr_e;

  typedef enum logic [2:0] {
    mode_direct    = 3'd0,
    mode_reversed  = 3'd1,
    mode_all_on    = 3'd2,
    mode_off       = 3'd3,
    mode_heartbeat = 3'd4  // 5..7 leds off
  } led_mode_e;

  typedef struct packed {
    spi_op_e   op;    // upper nibble
    reg_addr_e addr;  // lower nibble
  } spi_cmd_t;

  typedef struct packed {
    spi_cmd_t cmd;    // first on the wire
    word_t    data;
  } spi_frame_t;

  // control registers as seen by the muxes
  typedef struct packed {
    logic [LANE_COUNT-1:0] spi_mux;  // lane select mask
    logic                  oe_4094;  // relay chain output enable
    led_mode_e             mode;     // mode reg bits 2..0
    word_t                 direct;
    logic [19:0]           spare;    // mode reg bits 22..3, read back only
  } ctl_regs_t;

  typedef struct packed {
    logic [LANE_COUNT-1:0] lane_cs;
    logic [LANE_COUNT-1:0] lane_clk;
    logic [LANE_COUNT-1:0] lane_mosi;
  } lane_bus_t;

endpackage
